//--- logic/sd_init_pkg.sv
// shared constants, vector types and sequencer states for the sd card cmd0 start-up
package sd_init_pkg;

    // ====================
    // vector types
    // ====================
    typedef logic [7:0]  spi_byte_t;
    typedef logic [7:0]  ascii_t;
    // dummy, command and poll byte counter
    typedef logic [6:0]  byte_count_t;
    // sclk half period counter
    typedef logic [6:0]  div_count_t;
    typedef logic [31:0] delay_count_t;

    // sequencer states, in order of the start-up flow
    typedef enum logic [2:0] {
        st_power_up,
        st_dummy_clocks,
        st_send_cmd0,
        st_poll_r1,
        st_report,
        st_release_cs,
        st_done
    } seq_state_t;

    // ====================
    // timing
    // ====================
    // one second at 50 MHz
    localparam delay_count_t POWER_UP_CYCLES = 32'd50_000_000;
    // 50 MHz / 128 = 390.625 kHz, below the 400 kHz init limit
    localparam int unsigned  SCLK_HALF_DIV   = 64;

    // ====================
    // sd protocol
    // ====================
    localparam spi_byte_t    DUMMY_BYTE       = 8'hFF;
    // 10 bytes of 0xFF give the 80 wake-up clocks
    localparam byte_count_t  DUMMY_BYTE_COUNT = 7'd10;
    localparam byte_count_t  CMD0_LEN         = 7'd6;
    // go_idle_state, arg 0, crc 0x95
    localparam logic [47:0]  CMD0_FRAME       = 48'h40_00_00_00_00_95;
    localparam byte_count_t  POLL_LIMIT       = 7'd100;
    localparam spi_byte_t    R1_IDLE          = 8'h01;
    localparam spi_byte_t    R1_NONE          = 8'hFF;

    // ====================
    // status characters
    // ====================
    localparam ascii_t CHAR_START = "S";
    localparam ascii_t CHAR_SPACE = " ";
    localparam ascii_t CHAR_IDLE  = "1";
    localparam ascii_t CHAR_NONE  = "F";
    localparam ascii_t CHAR_OTHER = "X";

endpackage

//--- logic/spi_byte_engine.sv
// spi mode-0 master, one byte out and one byte in per start pulse
module spi_byte_engine
    import sd_init_pkg::*;
(
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      xfer_start,
    input  spi_byte_t tx_byte,
    input  logic      spi_miso,
    output logic      xfer_busy,
    output logic      xfer_done,
    output spi_byte_t rx_byte,
    output logic      spi_sclk,
    output logic      spi_mosi
);

    // ====================
    // divider and edges
    // ====================
    div_count_t div_cnt;
    // 16 sclk edges per byte, odd ones are falling
    logic [3:0] edge_cnt;
    spi_byte_t  tx_shift;
    spi_byte_t  rx_shift;

    logic accept;
    logic half_tick;
    logic rise_tick;
    logic fall_tick;
    logic last_edge;

    // new byte only taken while idle
    assign accept    = xfer_start && !xfer_busy;
    // end of one sclk half period
    assign half_tick = xfer_busy && (div_cnt == div_count_t'(SCLK_HALF_DIV - 1));
    assign rise_tick = half_tick && !spi_sclk;
    assign fall_tick = half_tick && spi_sclk;
    // eighth falling edge ends the byte
    assign last_edge = fall_tick && (edge_cnt == 4'd15);

    // ====================
    // control
    // ====================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            xfer_busy <= 1'b0;
            xfer_done <= 1'b0;
            spi_sclk  <= 1'b0;
            spi_mosi  <= 1'b1;
            div_cnt   <= '0;
            edge_cnt  <= '0;
        end else begin
            xfer_done <= 1'b0;
            if (accept) begin
                // msb goes out before the first rising edge
                xfer_busy <= 1'b1;
                spi_mosi  <= tx_byte[7];
                div_cnt   <= '0;
                edge_cnt  <= '0;
            end else if (xfer_busy) begin
                if (half_tick) begin
                    div_cnt  <= '0;
                    spi_sclk <= !spi_sclk;
                    edge_cnt <= edge_cnt + 1'b1;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
                // mosi moves on the falling edge
                if (last_edge) begin
                    xfer_busy <= 1'b0;
                    xfer_done <= 1'b1;
                    spi_mosi  <= 1'b1;
                end else if (fall_tick) begin
                    spi_mosi <= tx_shift[6];
                end
            end
        end
    end

    // ====================
    // shift registers
    // ====================
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            tx_shift <= tx_byte;
        end else if (fall_tick) begin
            tx_shift <= {tx_shift[6:0], 1'b1};
        end
        // miso sampled as sclk rises
        if (rise_tick) begin
            rx_shift <= {rx_shift[6:0], spi_miso};
        end
        // all eight bits in by the last falling edge
        if (last_edge) begin
            rx_byte <= rx_shift;
        end
    end

endmodule

//--- logic/sd_cmd_sequencer.sv
// fsm that orders power-up delay, dummy clocks, cmd0 and the r1 poll
module sd_cmd_sequencer
    import sd_init_pkg::*;
#(
    parameter delay_count_t power_up_cycles = POWER_UP_CYCLES
) (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      xfer_busy,
    input  logic      xfer_done,
    input  spi_byte_t rx_byte,
    output logic      xfer_start,
    output spi_byte_t tx_byte,
    output logic      cs_active,
    output logic      spi_ss_n,
    output logic      power_up_done,
    output logic      r1_valid,
    output spi_byte_t r1_byte
);

    // ====================
    // state and counters
    // ====================
    seq_state_t   state;
    delay_count_t delay_cnt;
    // counts finished transfers, reused as a cycle count in st_report
    byte_count_t  byte_cnt;
    // high from start pulse until done, covers the cycle before busy rises
    logic         xfer_pending;
    logic         can_launch;

    // engine is idle and nothing is in flight
    assign can_launch = !xfer_pending && !xfer_busy;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state         <= st_power_up;
            delay_cnt     <= '0;
            byte_cnt      <= '0;
            xfer_pending  <= 1'b0;
            xfer_start    <= 1'b0;
            tx_byte       <= DUMMY_BYTE;
            cs_active     <= 1'b0;
            spi_ss_n      <= 1'b1;
            power_up_done <= 1'b0;
            r1_valid      <= 1'b0;
            r1_byte       <= R1_NONE;
        end else begin
            // strobes default low
            xfer_start    <= 1'b0;
            power_up_done <= 1'b0;
            r1_valid      <= 1'b0;

            if (xfer_done) begin
                xfer_pending <= 1'b0;
            end

            case (state)
                // wait for card supply to settle
                st_power_up: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == power_up_cycles - 1) begin
                        power_up_done <= 1'b1;
                        byte_cnt      <= '0;
                        state         <= st_dummy_clocks;
                    end
                end

                // 0xFF bytes with cs high, 8 clocks each
                st_dummy_clocks: begin
                    if (can_launch) begin
                        xfer_start   <= 1'b1;
                        xfer_pending <= 1'b1;
                        tx_byte      <= DUMMY_BYTE;
                    end
                    if (xfer_done) begin
                        if (byte_cnt == DUMMY_BYTE_COUNT - 1'b1) begin
                            // sclk is already low here, safe to drop cs
                            byte_cnt  <= '0;
                            cs_active <= 1'b1;
                            spi_ss_n  <= 1'b0;
                            state     <= st_send_cmd0;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end

                // cmd0 frame, first byte is the top of the vector
                st_send_cmd0: begin
                    if (can_launch) begin
                        xfer_start   <= 1'b1;
                        xfer_pending <= 1'b1;
                        tx_byte      <= CMD0_FRAME[(CMD0_LEN - 1'b1 - byte_cnt) * 8 +: 8];
                    end
                    if (xfer_done) begin
                        if (byte_cnt == CMD0_LEN - 1'b1) begin
                            byte_cnt <= '0;
                            state    <= st_poll_r1;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end

                // clock out 0xFF until r1 shows up
                st_poll_r1: begin
                    if (can_launch) begin
                        xfer_start   <= 1'b1;
                        xfer_pending <= 1'b1;
                        tx_byte      <= DUMMY_BYTE;
                    end
                    if (xfer_done) begin
                        if (!rx_byte[7]) begin
                            // r1 always starts with a zero bit
                            r1_byte  <= rx_byte;
                            r1_valid <= 1'b1;
                            byte_cnt <= '0;
                            state    <= st_report;
                        end else if (byte_cnt == POLL_LIMIT - 1'b1) begin
                            // card never answered
                            r1_byte  <= R1_NONE;
                            r1_valid <= 1'b1;
                            byte_cnt <= '0;
                            state    <= st_report;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end

                // console emits space then result over the next two cycles
                st_report: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 7'd2) begin
                        state <= st_release_cs;
                    end
                end

                // deselect the card after reporting
                st_release_cs: begin
                    cs_active <= 1'b0;
                    spi_ss_n  <= 1'b1;
                    state     <= st_done;
                end

                // hold here until next reset
                st_done: begin
                    state <= st_done;
                end

                default: begin
                    state <= st_done;
                end
            endcase
        end
    end

endmodule

//--- logic/status_console.sv
// turns sequence events into start, space and result character strobes
module status_console
    import sd_init_pkg::*;
(
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      power_up_done,
    input  logic      r1_valid,
    input  spi_byte_t r1_byte,
    output logic      char_valid,
    output ascii_t    char_data
);

    // result waits one cycle behind the space
    logic   result_pending;
    ascii_t result_char;

    // r1 value to printable result
    function automatic ascii_t r1_to_char(input spi_byte_t r1);
        if (r1 == R1_IDLE) begin
            return CHAR_IDLE;
        end else if (r1 == R1_NONE) begin
            return CHAR_NONE;
        end
        return CHAR_OTHER;
    endfunction

    // ====================
    // strobe control
    // ====================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            char_valid     <= 1'b0;
            result_pending <= 1'b0;
        end else begin
            char_valid     <= power_up_done || r1_valid || result_pending;
            result_pending <= r1_valid;
        end
    end

    // character payload
    always_ff @(posedge CLOCK_50) begin
        if (power_up_done) begin
            char_data <= CHAR_START;
        end else if (r1_valid) begin
            char_data   <= CHAR_SPACE;
            result_char <= r1_to_char(r1_byte);
        end else if (result_pending) begin
            char_data <= result_char;
        end
    end

endmodule

//--- logic/sd_init_top.sv
// board top for the sd card cmd0 start-up with status character output
module sd_init_top
    import sd_init_pkg::*;
#(
    parameter delay_count_t power_up_cycles = POWER_UP_CYCLES
) (
    input  logic   CLOCK_50,
    input  logic   KEY0,
    input  logic   spi_miso,
    output logic   spi_sclk,
    output logic   spi_mosi,
    output logic   spi_ss_n,
    output logic   ledr0,
    output logic   char_valid,
    output ascii_t char_data
);

    // ====================
    // internal nets
    // ====================
    // sequencer <-> byte engine
    logic      xfer_start;
    logic      xfer_busy;
    logic      xfer_done;
    spi_byte_t tx_byte;
    spi_byte_t rx_byte;

    // sequencer -> console events
    logic      power_up_done;
    logic      r1_valid;
    spi_byte_t r1_byte;

    // command sequencer, cs level also lights the led
    sd_cmd_sequencer #(
        .power_up_cycles (power_up_cycles)
    ) sequencer_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .xfer_busy     (xfer_busy),
        .xfer_done     (xfer_done),
        .rx_byte       (rx_byte),
        .xfer_start    (xfer_start),
        .tx_byte       (tx_byte),
        .cs_active     (ledr0),
        .spi_ss_n      (spi_ss_n),
        .power_up_done (power_up_done),
        .r1_valid      (r1_valid),
        .r1_byte       (r1_byte)
    );

    // spi mode-0 byte shifter
    spi_byte_engine engine_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .xfer_start (xfer_start),
        .tx_byte    (tx_byte),
        .spi_miso   (spi_miso),
        .xfer_busy  (xfer_busy),
        .xfer_done  (xfer_done),
        .rx_byte    (rx_byte),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi)
    );

    // character strobes for the host side
    status_console console_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .power_up_done (power_up_done),
        .r1_valid      (r1_valid),
        .r1_byte       (r1_byte),
        .char_valid    (char_valid),
        .char_data     (char_data)
    );

endmodule

//--- testbench/tb_clock_gen.sv
// testbench clock and reset source, 8 unit period, reset held low for 8 cycles
module tb_clock_gen (
    input  logic reset_req,
    output logic CLOCK_50,
    output logic KEY0
);

    int   hold_cnt;
    logic restart;

    initial begin
        CLOCK_50 = 1'b0;
        KEY0     = 1'b0;
        hold_cnt = 0;
    end

    always #4 CLOCK_50 = ~CLOCK_50;

    // request sampled on the edge, reset moves just after it
    always @(posedge CLOCK_50) begin
        restart = reset_req;
        #1;
        if (restart) begin
            hold_cnt = 0;
            KEY0     = 1'b0;
        end else if (hold_cnt == 7) begin
            KEY0 = 1'b1;
        end else begin
            hold_cnt = hold_cnt + 1;
        end
    end

endmodule

//--- testbench/sd_init_assert.sv
// concurrent checks on the spi pins and the character strobe of sd_init_top
module sd_init_assert (
    input logic CLOCK_50,
    input logic KEY0,
    input logic spi_sclk,
    input logic spi_ss_n,
    input logic spi_mosi,
    input logic char_valid
);

    // failed assertion count, read by the testbench top
    int fail_cnt = 0;

    // ====================
    // spi pins
    // ====================
    // chip select only moves while sclk idles low
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $changed(spi_ss_n) |-> !spi_sclk)
        else begin
            $error("spi_ss_n changed while spi_sclk was high");
            fail_cnt = fail_cnt + 1;
        end

    // mosi always driven once out of reset
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !$isunknown(spi_mosi))
        else begin
            $error("spi_mosi is unknown");
            fail_cnt = fail_cnt + 1;
        end

    // ====================
    // character strobe
    // ====================
    // space and result come back to back, never three in a row
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        char_valid ##1 char_valid |=> !char_valid)
        else begin
            $error("char_valid stayed high for three cycles");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind sd_init_top sd_init_assert assert_i (
    .CLOCK_50   (CLOCK_50),
    .KEY0       (KEY0),
    .spi_sclk   (spi_sclk),
    .spi_ss_n   (spi_ss_n),
    .spi_mosi   (spi_mosi),
    .char_valid (char_valid)
);

//--- testbench/tb_sd_init.sv
// testbench top, runs sd_init_top through cmd0 start-up against a small sd card model
module tb_sd_init
    import sd_init_pkg::*;
();

    localparam int NUM_RUNS     = 8;
    localparam int QUIET_CYCLES = 2000;
    // power-up, 118 transfers with launch slack, then margin
    localparam int CYCLE_LIMIT  = 200 + 118 * (16 * SCLK_HALF_DIV + 2) + 500;

    logic   CLOCK_50;
    logic   KEY0;
    logic   reset_req;
    logic   spi_miso;
    logic   spi_sclk;
    logic   spi_mosi;
    logic   spi_ss_n;
    logic   ledr0;
    logic   char_valid;
    ascii_t char_data;

    // three bytes per run from the data file
    logic [7:0] run_data [0:NUM_RUNS*3-1];
    spi_byte_t  cmd0_expect [0:5] = '{8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95};

    // ====================
    // card model state
    // ====================
    int        reply_delay;
    spi_byte_t r1_value;
    int        bit_cnt;
    // bytes completed with cs low
    int        sel_bytes;
    spi_byte_t card_rx;
    spi_byte_t card_tx;
    spi_byte_t cmd_seen [0:5];

    // observation counters
    int   edge_total;
    int   high_edges;
    int   mosi_low_edges;
    int   char_count;
    int   cycle_cnt;
    logic seq_running;

    tb_clock_gen clock_gen_i (
        .reset_req (reset_req),
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0)
    );

    sd_init_top #(
        .power_up_cycles (32'd200)
    ) dut_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .spi_miso   (spi_miso),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_ss_n   (spi_ss_n),
        .ledr0      (ledr0),
        .char_valid (char_valid),
        .char_data  (char_data)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // r1 after reply_delay poll bytes, idle 0xFF otherwise
    function automatic spi_byte_t card_reply(input int seen);
        if (seen >= 6 && seen - 6 == reply_delay) begin
            return r1_value;
        end
        return 8'hFF;
    endfunction

    // ====================
    // card model
    // ====================
    // mosi taken on rising sclk
    always @(posedge spi_sclk) begin
        edge_total = edge_total + 1;
        if (spi_ss_n) begin
            high_edges = high_edges + 1;
            if (spi_mosi !== 1'b1) begin
                mosi_low_edges = mosi_low_edges + 1;
            end
        end
        card_rx = {card_rx[6:0], spi_mosi};
        bit_cnt = bit_cnt + 1;
        if (bit_cnt == 8) begin
            bit_cnt = 0;
            if (!spi_ss_n) begin
                if (sel_bytes < 6) begin
                    cmd_seen[sel_bytes] = card_rx;
                end
                sel_bytes = sel_bytes + 1;
            end
        end
    end

    // miso moves after falling sclk, next byte loaded at a byte boundary
    always @(negedge spi_sclk) begin
        #1;
        if (bit_cnt == 0) begin
            card_tx = card_reply(sel_bytes);
        end else begin
            card_tx = {card_tx[6:0], 1'b1};
        end
        spi_miso = card_tx[7];
    end

    // strobe count and watchdog
    always @(posedge CLOCK_50) begin
        if (KEY0 && char_valid) begin
            char_count = char_count + 1;
        end
        // stop at the first failed bound assertion
        if (dut_i.assert_i.fail_cnt != 0) begin
            $display("a bound assertion on the spi pins or char strobe failed");
            $display("Result: FAILED");
            $fatal(1, "assertion failure");
        end
        if (seq_running) begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > CYCLE_LIMIT) begin
                $display("timeout: start-up sequence never finished in %0d cycles",
                         CYCLE_LIMIT);
                $display("Result: FAILED");
                $fatal(1, "sequence timeout");
            end
        end
    end

    // waits for the next strobe, sampled just after the edge
    task automatic wait_char(output ascii_t c);
        do begin
            @(posedge CLOCK_50);
            #1;
        end while (!char_valid);
        c = char_data;
    endtask

    task automatic run_case(input int delay, input spi_byte_t r1, input ascii_t expect_char);
        ascii_t c;
        int     edges_done;
        // fresh reset, card back to its idle state
        @(posedge CLOCK_50);
        #1;
        reset_req = 1'b1;
        @(posedge CLOCK_50);
        #1;
        reset_req      = 1'b0;
        reply_delay    = delay;
        r1_value       = r1;
        bit_cnt        = 0;
        sel_bytes      = 0;
        card_tx        = 8'hFF;
        spi_miso       = 1'b1;
        edge_total     = 0;
        high_edges     = 0;
        mosi_low_edges = 0;
        char_count     = 0;
        cycle_cnt      = 0;
        foreach (cmd_seen[i]) begin
            cmd_seen[i] = 8'hxx;
        end
        @(posedge KEY0);
        seq_running = 1'b1;
        check_value("spi_ss_n", spi_ss_n, 1);
        check_value("ledr0", ledr0, 0);
        check_value("char_valid", char_valid, 0);
        // start char, no sclk before it
        wait_char(c);
        check_value("sclk edges before start char", edge_total, 0);
        check_value("char_data", c, "S");
        // 80 wake-up clocks with cs and mosi high
        @(negedge spi_ss_n);
        check_value("sclk edges with spi_ss_n high", high_edges, 80);
        check_value("sclk edges with spi_mosi low", mosi_low_edges, 0);
        wait_char(c);
        check_value("char_data", c, " ");
        // card still selected while reporting
        check_value("ledr0", ledr0, 1);
        wait_char(c);
        check_value("char_data", c, expect_char);
        for (int i = 0; i < 6; i++) begin
            check_value($sformatf("cmd0 byte %0d", i), cmd_seen[i], cmd0_expect[i]);
        end
        if (spi_ss_n !== 1'b1) begin
            @(posedge spi_ss_n);
        end
        seq_running = 1'b0;
        // quiet after release
        edges_done = edge_total;
        repeat (QUIET_CYCLES) begin
            @(posedge CLOCK_50);
            #1;
            check_value("spi_ss_n", spi_ss_n, 1);
            check_value("ledr0", ledr0, 0);
        end
        check_value("sclk edges after release", edge_total, edges_done);
        check_value("char_valid pulses", char_count, 3);
    endtask

    // ====================
    // main flow
    // ====================
    initial begin
        reset_req   = 1'b0;
        spi_miso    = 1'b1;
        seq_running = 1'b0;
        $readmemh("testbench/sd_init_input.txt", run_data);
        if ($isunknown(run_data[0]) || $isunknown(run_data[NUM_RUNS*3-1])) begin
            $display("could not read the stimulus file testbench/sd_init_input.txt");
            $display("Result: FAILED");
            $fatal(1, "missing stimulus");
        end
        for (int i = 0; i < NUM_RUNS; i++) begin
            $display("run %0d: r1 %02h after %0d poll bytes",
                     i, run_data[3*i+1], run_data[3*i]);
            run_case(int'(run_data[3*i]), run_data[3*i+1], run_data[3*i+2]);
        end
        if (dut_i.assert_i.fail_cnt != 0) begin
            $display("a bound assertion failed in the last cycle of the run");
            $display("Result: FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- sd_init.f
logic/sd_init_pkg.sv
logic/spi_byte_engine.sv
logic/sd_cmd_sequencer.sv
logic/status_console.sv
logic/sd_init_top.sv
testbench/tb_clock_gen.sv
testbench/sd_init_assert.sv
testbench/tb_sd_init.sv

//--- Bender.yml
package:
  name: sd_init

sources:
  # rtl, package first
  - logic/sd_init_pkg.sv
  - logic/spi_byte_engine.sv
  - logic/sd_cmd_sequencer.sv
  - logic/status_console.sv
  - logic/sd_init_top.sv
  # testbench
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/sd_init_assert.sv
      - testbench/tb_sd_init.sv

//--- testbench/sd_init_input.txt
// columns: reply_delay r1_value expected_char, all hex, char as its ascii code
// reply_delay counts 0xFF poll bytes the card sends before its r1 byte
00 01 31
03 01 31
32 01 31
63 01 31
02 05 58
05 00 58
64 01 46
78 01 46
